/* build.f */
src/axi_st_link_pkg.sv
src/st_online_delay.sv
src/st_user_packer.sv
src/st_credit_transmit.sv
src/st_phy_framer.sv
src/axi_st_link_top.sv
test/tb_axi_st_link.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi_st_link -f build.f \
  && ./obj_dir/Vtb_axi_st_link | tee /dev/stderr | grep "Everything OK" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* test/tb_axi_st_link.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the AXI-stream link transmit side
// Drives user beats, models the link partner that returns credits, and
// checks tx_phy0 against a reference packing of the accepted beats
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_axi_st_link;
  import axi_st_link_pkg::*;

  localparam int fifo_depth    = 4;
  localparam int strobe_period = 16;
  localparam int credit_init   = 5;
  localparam int delay_x       = 12;
  localparam int random_beats  = 60;
  // Beats up to the credit stall and then the random run
  localparam int total_beats   = credit_init + fifo_depth + 1 + random_beats;

  // DUT ports
  logic        clk_wr = 1'b0;
  logic        reset;
  logic        tx_online;
  logic [7:0]  init_st_credit;
  logic [15:0] delay_x_value;
  logic [79:0] tx_phy0;
  logic [79:0] rx_phy0 = '0;
  logic [7:0]  user_tkeep = 8'd0;
  logic [63:0] user_tdata = 64'd0;
  logic        user_tlast = 1'b0;
  logic        user_tvalid = 1'b0;
  logic        user_tready;
  logic [31:0] tx_st_debug_status;

  // Scoreboard
  logic [72:0] expected_q[$];
  int          credit_due[$];
  logic [72:0] exp_word;
  logic [72:0] got_word;
  logic [7:0]  exp_credit;
  int          cycle = 0;
  int          accepted_cnt = 0;
  int          push_count = 0;
  int          return_count = 0;
  int          monitor_errors = 0;
  int          seq_errors = 0;
  int          last_strobe = 0;
  logic        seen_strobe = 1'b0;
  logic        beat_taken = 1'b0;
  logic        use_gaps;
  logic        hold_credits;
  logic        timed_out;

  axi_st_link_top #(
    .fifo_depth    (fifo_depth),
    .strobe_period (strobe_period)
  ) i_dut (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .tx_online          (tx_online),
    .init_st_credit     (init_st_credit),
    .delay_x_value      (delay_x_value),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .tx_st_debug_status (tx_st_debug_status)
  );

  always #20 clk_wr = ~clk_wr;

  always @(posedge clk_wr) begin
    cycle <= cycle + 1;
  end

  // Expected link word with tdata low, tkeep above and tlast on top
  function automatic logic [72:0] pack_word(input logic [63:0] tdata,
                                            input logic [7:0] tkeep,
                                            input logic tlast);
    logic [72:0] w;
    w[63:0]  = tdata;
    w[71:64] = tkeep;
    w[72]    = tlast;
    return w;
  endfunction

  task automatic note_timeout(input string what);
    $display("Timed out waiting for %s", what);
    timed_out = 1'b1;
    seq_errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // User beat driver
  always @(posedge clk_wr) begin
    #1;
    if (beat_taken) begin
      user_tvalid = 1'b0;
    end
    if (!reset && !user_tvalid && accepted_cnt < total_beats) begin
      // One idle cycle in four when gaps are on
      if (!use_gaps || $urandom_range(3, 0) != 0) begin
        user_tdata  = {$urandom(), $urandom()};
        user_tkeep  = 8'($urandom());
        user_tlast  = ($urandom_range(7, 0) == 0);
        user_tvalid = 1'b1;
      end
    end
  end

  // Link partner returns one credit per received word after 0 to 6 cycles
  always @(posedge clk_wr) begin
    #1;
    rx_phy0 = '0;
    if (!reset) begin
      if (tx_phy0[phy_push_bit]) begin
        credit_due.push_back(cycle + int'($urandom_range(6, 0)));
      end
      if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle) begin
        void'(credit_due.pop_front());
        rx_phy0[phy_credit_bit] = 1'b1;
        return_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor and compare at mid-cycle
  always @(negedge clk_wr) begin
    beat_taken = 1'b0;
    if (!reset) begin
      // Strobe spacing
      if (tx_phy0[phy_strobe_bit]) begin
        if (seen_strobe) begin
          assert (cycle - last_strobe == strobe_period) else begin
            $display("ERROR strobe spacing got %h expected %h",
                     cycle - last_strobe, strobe_period);
            monitor_errors++;
          end
        end
        seen_strobe = 1'b1;
        last_strobe = cycle;
      end
      if (tx_phy0[phy_push_bit]) begin
        push_count++;
        assert (seen_strobe) else begin
          $display("Push bit seen in tx_phy0 before the first strobe");
          monitor_errors++;
        end
        assert (expected_q.size() != 0) else begin
          $display("Push bit seen in tx_phy0 with no accepted beat left to send");
          monitor_errors++;
        end
        if (expected_q.size() != 0) begin
          exp_word = expected_q.pop_front();
          got_word = tx_phy0[phy_data_lsb +: st_word_width];
          assert (got_word == exp_word) else begin
            $display("ERROR tx_phy0[73:1] got %h expected %h", got_word, exp_word);
            monitor_errors++;
          end
        end
      end
      assert (tx_phy0[78:74] == 5'd0) else begin
        $display("ERROR tx_phy0[78:74] got %h expected %h", tx_phy0[78:74], 5'd0);
        monitor_errors++;
      end
      // Beat taken at the coming edge
      if (user_tvalid && user_tready) begin
        expected_q.push_back(pack_word(user_tdata, user_tkeep, user_tlast));
        accepted_cnt++;
        beat_taken = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test phases
  task automatic check_offline();
    repeat (20) begin
      @(negedge clk_wr);
      assert (tx_phy0 == '0) else begin
        $display("ERROR tx_phy0 got %h expected %h", tx_phy0, 80'd0);
        seq_errors++;
      end
      assert (tx_st_debug_status[7:0] == 8'd0) else begin
        $display("ERROR tx_st_debug_status[7:0] got %h expected %h",
                 tx_st_debug_status[7:0], 8'd0);
        seq_errors++;
      end
    end
    // Packer register plus a full FIFO
    assert (accepted_cnt == fifo_depth + 1 && !user_tready) else begin
      $display("Offline link did not hold exactly %0d beats", fifo_depth + 1);
      seq_errors++;
    end
  endtask

  task automatic check_first_strobe();
    int edges;
    edges = 0;
    @(posedge clk_wr);
    #1;
    tx_online = 1'b1;
    while (!tx_phy0[phy_strobe_bit] && edges < 1000) begin
      @(posedge clk_wr);
      edges++;
      @(negedge clk_wr);
    end
    if (!tx_phy0[phy_strobe_bit]) begin
      note_timeout("the first strobe");
      return;
    end
    assert (edges == delay_x + 3) else begin
      $display("ERROR first strobe delay got %h expected %h", edges, delay_x + 3);
      seq_errors++;
    end
  endtask

  task automatic check_credit_limit();
    int n;
    n = 0;
    while (push_count < credit_init && n < 500) begin
      @(negedge clk_wr);
      n++;
    end
    if (push_count < credit_init) begin
      note_timeout("the pushes allowed by the initial credit");
      return;
    end
    n = 0;
    while (user_tready && n < 500) begin
      @(negedge clk_wr);
      n++;
    end
    if (user_tready) begin
      note_timeout("user_tready to fall with no credit left");
      return;
    end
    assert (accepted_cnt == credit_init + fifo_depth + 1) else begin
      $display("ERROR accepted beats got %h expected %h",
               accepted_cnt, credit_init + fifo_depth + 1);
      seq_errors++;
    end
    // Stalled link stays stalled
    repeat (20) @(negedge clk_wr);
    assert (push_count == credit_init && !user_tready) else begin
      $display("Link moved data while it held no credit");
      seq_errors++;
    end
  endtask

  task automatic check_credit_return();
    int n;
    n = 0;
    hold_credits = 1'b0;
    use_gaps     = 1'b1;
    while ((push_count < total_beats || credit_due.size() != 0) && n < 5000) begin
      @(negedge clk_wr);
      n++;
    end
    if (push_count < total_beats || credit_due.size() != 0) begin
      note_timeout("all beats to be pushed and credited");
      return;
    end
    // Quiet point
    repeat (10) @(negedge clk_wr);
    exp_credit = 8'(credit_init + return_count - push_count);
    assert (tx_st_debug_status[7:0] == exp_credit) else begin
      $display("ERROR tx_st_debug_status[7:0] got %h expected %h",
               tx_st_debug_status[7:0], exp_credit);
      seq_errors++;
    end
    assert (tx_st_debug_status[15:8] == 8'd0) else begin
      $display("ERROR tx_st_debug_status[15:8] got %h expected %h",
               tx_st_debug_status[15:8], 8'd0);
      seq_errors++;
    end
    assert (tx_st_debug_status[31:16] == 16'(push_count)) else begin
      $display("ERROR tx_st_debug_status[31:16] got %h expected %h",
               tx_st_debug_status[31:16], 16'(push_count));
      seq_errors++;
    end
    assert (expected_q.size() == 0) else begin
      $display("Accepted beats never showed up on tx_phy0");
      seq_errors++;
    end
    // Strobes keep coming while online
    assert (cycle - last_strobe <= strobe_period) else begin
      $display("Strobes stopped while the link was online");
      seq_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    void'($urandom(7));
    reset          = 1'b1;
    tx_online      = 1'b0;
    init_st_credit = 8'(credit_init);
    delay_x_value  = 16'(delay_x);
    use_gaps       = 1'b0;
    hold_credits   = 1'b1;
    timed_out      = 1'b0;
    repeat (3) @(posedge clk_wr);
    #1;
    reset = 1'b0;

    check_offline();
    if (!timed_out) begin
      check_first_strobe();
    end
    if (!timed_out) begin
      check_credit_limit();
    end
    if (!timed_out) begin
      check_credit_return();
    end

    $display("Run finished with %0d monitor errors and %0d sequence errors",
             monitor_errors, seq_errors);
    if (monitor_errors == 0 && seq_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* src/axi_st_link_top.sv */
////////////////////////////////////////////////////////////////////////////
// AXI-stream die-to-die link, transmit top level
// User packer, credit transmitter, online delay and PHY framer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_st_link_top #(
  parameter int fifo_depth    = 4,
  parameter int strobe_period = 16
) (
  input  logic                                     clk_wr,
  input  logic                                     reset,

  // Control
  input  logic                                     tx_online,
  input  logic [axi_st_link_pkg::credit_width-1:0] init_st_credit,
  input  logic [15:0]                              delay_x_value,

  // PHY interconnect
  output logic [axi_st_link_pkg::phy_width-1:0]    tx_phy0,
  input  logic [axi_st_link_pkg::phy_width-1:0]    rx_phy0,

  // AXI-stream user channel
  input  logic [axi_st_link_pkg::st_keep_width-1:0] user_tkeep,
  input  logic [axi_st_link_pkg::st_data_width-1:0] user_tdata,
  input  logic                                     user_tlast,
  input  logic                                     user_tvalid,
  output logic                                     user_tready,

  // Debug status
  output logic [31:0]                              tx_st_debug_status
);
  import axi_st_link_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  logic                     tx_online_delay;
  logic                     tx_strobe;
  logic                     word_valid;
  logic                     word_ready;
  logic [st_word_width-1:0] word_data;
  logic [st_word_width-1:0] tx_word;
  logic                     tx_push;
  logic                     credit_return;

  // Online delay and strobe
  st_online_delay #(
    .strobe_period (strobe_period)
  ) i_online_delay (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .delay_x_value   (delay_x_value),
    .tx_online_delay (tx_online_delay),
    .tx_strobe       (tx_strobe)
  );

  // User side
  st_user_packer i_user_packer (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .word_valid  (word_valid),
    .word_data   (word_data),
    .word_ready  (word_ready)
  );

  // Credit transmitter
  st_credit_transmit #(
    .fifo_depth (fifo_depth)
  ) i_credit_transmit (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .tx_online_delay    (tx_online_delay),
    .init_st_credit     (init_st_credit),
    .word_valid         (word_valid),
    .word_data          (word_data),
    .word_ready         (word_ready),
    .credit_return      (credit_return),
    .tx_word            (tx_word),
    .tx_push            (tx_push),
    .tx_st_debug_status (tx_st_debug_status)
  );

  // PHY side
  st_phy_framer i_phy_framer (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online_delay (tx_online_delay),
    .tx_word         (tx_word),
    .tx_push         (tx_push),
    .tx_strobe       (tx_strobe),
    .tx_phy0         (tx_phy0),
    .rx_phy0         (rx_phy0),
    .credit_return   (credit_return)
  );

endmodule

/* src/st_phy_framer.sv */
////////////////////////////////////////////////////////////////////////////
// PHY framer
// Registers the 80-bit PHY transmit word with push, data and strobe, and
// recovers the credit-return pulse from the PHY receive word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_phy_framer (
  input  logic                                      clk_wr,
  input  logic                                      reset,
  input  logic                                      tx_online_delay,

  // From the transmitter and the online delay
  input  logic [axi_st_link_pkg::st_word_width-1:0] tx_word,
  input  logic                                      tx_push,
  input  logic                                      tx_strobe,

  // PHY words
  output logic [axi_st_link_pkg::phy_width-1:0]     tx_phy0,
  input  logic [axi_st_link_pkg::phy_width-1:0]     rx_phy0,

  // Credit pulse back to the transmitter
  output logic                                      credit_return
);
  import axi_st_link_pkg::*;

  logic [phy_width-1:0] phy_next;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit word assembly
  always_comb begin
    // Reserved bits default to zero
    phy_next = '0;
    phy_next[phy_push_bit] = tx_push;
    // Data only rides along with a push
    if (tx_push) begin
      phy_next[phy_data_lsb +: st_word_width] = tx_word;
    end
    phy_next[phy_strobe_bit] = tx_strobe;
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= phy_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit return
  // Pulses outside the online window are dropped
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= rx_phy0[phy_credit_bit] && tx_online_delay;
    end
  end

endmodule

/* src/st_credit_transmit.sv */
////////////////////////////////////////////////////////////////////////////
// Credit-based transmitter
// Buffers link words in a FIFO and pops one per cycle while online and
// holding a credit from the far side. Reports credit, fill and push count.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_credit_transmit #(
  parameter int fifo_depth = 4
) (
  input  logic                                      clk_wr,
  input  logic                                      reset,
  input  logic                                      tx_online_delay,
  input  logic [axi_st_link_pkg::credit_width-1:0]  init_st_credit,

  // Words from the packer
  input  logic                                      word_valid,
  input  logic [axi_st_link_pkg::st_word_width-1:0] word_data,
  output logic                                      word_ready,

  // Credit pulses from the framer
  input  logic                                      credit_return,

  // Words to the framer
  output logic [axi_st_link_pkg::st_word_width-1:0] tx_word,
  output logic                                      tx_push,

  output logic [31:0]                               tx_st_debug_status
);
  import axi_st_link_pkg::*;

  localparam int ptr_width  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int fill_width = $clog2(fifo_depth + 1);
  localparam logic [ptr_width-1:0]  ptr_last  = ptr_width'(fifo_depth - 1);
  localparam logic [fill_width-1:0] fill_full = fill_width'(fifo_depth);

  logic [st_word_width-1:0] fifo_mem [fifo_depth];
  logic [ptr_width-1:0]     wr_ptr;
  logic [ptr_width-1:0]     rd_ptr;
  logic [fill_width-1:0]    fill_cnt;
  logic [credit_width-1:0]  credit_cnt;
  logic                     online_q;
  logic [15:0]              push_cnt;
  logic                     fifo_wr;
  logic                     fifo_rd;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO
  assign word_ready = (fill_cnt != fill_full);
  assign fifo_wr    = word_valid && word_ready;
  // Pop needs data, link online and at least one credit
  assign fifo_rd    = (fill_cnt != '0) && tx_online_delay && (credit_cnt != '0);

  always_ff @(posedge clk_wr) begin
    if (fifo_wr) begin
      fifo_mem[wr_ptr] <= word_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + ptr_width'(1);
      end
      if (fifo_rd) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + ptr_width'(1);
      end
      case ({fifo_wr, fifo_rd})
        2'b10:   fill_cnt <= fill_cnt + fill_width'(1);
        2'b01:   fill_cnt <= fill_cnt - fill_width'(1);
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_cnt <= '0;
      online_q   <= 1'b0;
    end else begin
      online_q <= tx_online_delay;
      if (!tx_online_delay) begin
        credit_cnt <= '0;
      end else if (!online_q) begin
        // Rising edge of online loads the initial credit
        credit_cnt <= init_st_credit;
      end else begin
        case ({fifo_rd, credit_return})
          2'b10:   credit_cnt <= credit_cnt - credit_width'(1);
          // Hold at full scale rather than wrap
          2'b01:   if (credit_cnt != '1) credit_cnt <= credit_cnt + credit_width'(1);
          default: credit_cnt <= credit_cnt;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_push  <= 1'b0;
      push_cnt <= '0;
    end else begin
      tx_push <= fifo_rd;
      if (fifo_rd) begin
        push_cnt <= push_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (fifo_rd) begin
      tx_word <= fifo_mem[rd_ptr];
    end
  end

  // Push count, fill level, credit count
  assign tx_st_debug_status = {push_cnt, 8'(fill_cnt), 8'(credit_cnt)};

endmodule

/* src/st_user_packer.sv */
////////////////////////////////////////////////////////////////////////////
// AXI-stream user packer
// One-entry output register, packs tdata, tkeep and tlast into a link word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_user_packer (
  input  logic                                     clk_wr,
  input  logic                                     reset,

  // User AXI-stream beat
  input  logic [axi_st_link_pkg::st_data_width-1:0] user_tdata,
  input  logic [axi_st_link_pkg::st_keep_width-1:0] user_tkeep,
  input  logic                                     user_tlast,
  input  logic                                     user_tvalid,
  output logic                                     user_tready,

  // Packed link word to the transmitter
  output logic                                     word_valid,
  output logic [axi_st_link_pkg::st_word_width-1:0] word_data,
  input  logic                                     word_ready
);
  import axi_st_link_pkg::*;

  logic                     take_beat;
  logic [st_word_width-1:0] packed_word;

  // Free slot, or the held word leaves this cycle
  assign user_tready = !word_valid || word_ready;
  assign take_beat   = user_tvalid && user_tready;

  // Link word layout
  // tlast on top, then tkeep, then tdata
  assign packed_word = {user_tlast, user_tkeep, user_tdata};

  ////////////////////////////////////////////////////////////////////////////
  // Valid flag
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      word_valid <= 1'b0;
    end else if (take_beat) begin
      word_valid <= 1'b1;
    end else if (word_ready) begin
      word_valid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk_wr) begin
    if (take_beat) begin
      word_data <= packed_word;
    end
  end

endmodule

/* src/st_online_delay.sv */
////////////////////////////////////////////////////////////////////////////
// Online delay and strobe generator
// Holds the transmit path off for delay_x_value cycles after tx_online
// rises, then raises a strobe every strobe_period cycles while online
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_online_delay #(
  parameter int strobe_period = 16
) (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic        tx_online,
  input  logic [15:0] delay_x_value,
  output logic        tx_online_delay,
  output logic        tx_strobe
);
  import axi_st_link_pkg::*;

  localparam int stb_cnt_width = $clog2(strobe_period);
  localparam logic [stb_cnt_width-1:0] stb_cnt_last = stb_cnt_width'(strobe_period - 1);

  link_state_e              state;
  logic [15:0]              delay_cnt;
  logic [stb_cnt_width-1:0] stb_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state     <= link_offline;
      delay_cnt <= '0;
      stb_cnt   <= '0;
    end else begin
      case (state)
        link_offline: begin
          delay_cnt <= '0;
          if (tx_online) begin
            state <= link_waiting;
          end
        end
        link_waiting: begin
          // Count out the delay, one extra cycle for the state change
          if (!tx_online) begin
            state <= link_offline;
          end else if (delay_cnt >= delay_x_value) begin
            state   <= link_online;
            stb_cnt <= '0;
          end else begin
            delay_cnt <= delay_cnt + 16'd1;
          end
        end
        link_online: begin
          if (!tx_online) begin
            state <= link_offline;
          end
          // Strobe phase wraps every strobe_period cycles
          stb_cnt <= (stb_cnt == stb_cnt_last) ? '0 : stb_cnt + stb_cnt_width'(1);
        end
        default: state <= link_offline;
      endcase
    end
  end

  // Decoded outputs
  assign tx_online_delay = (state == link_online);
  // Strobe on the first online cycle, then each phase zero
  assign tx_strobe = tx_online_delay && (stb_cnt == '0);

endmodule

/* src/axi_st_link_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// AXI-stream die-to-die link, transmit side
// Shared widths, PHY bit positions and the online-delay state type
////////////////////////////////////////////////////////////////////////////

package axi_st_link_pkg;

  // User AXI-stream side
  localparam int st_data_width = 64;
  localparam int st_keep_width = 8;

  // Link word layout
  // tdata in 63..0, tkeep in 71..64, tlast in 72
  localparam int st_word_width = 73;

  // PHY word, one per clk_wr cycle
  localparam int phy_width      = 80;
  localparam int phy_push_bit   = 0;
  localparam int phy_data_lsb   = 1;
  // Bits 78..74 stay reserved at zero
  localparam int phy_strobe_bit = 79;

  // Credit return pulse from the far side
  localparam int phy_credit_bit = 0;

  // Credit counter and initial credit
  localparam int credit_width = 8;

  // Online delay FSM
  typedef enum logic [1:0] {
    link_offline,
    link_waiting,
    link_online
  } link_state_e;

endpackage
